// File: verilog.f
+incdir+rtl
rtl/operandPkg.sv
rtl/regFile.sv
rtl/insnDecoder.sv
rtl/regReadStage.sv
rtl/pipelineCtrl.sv
rtl/operandFetchTop.sv
sim/operandFetchTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = operandFetchTb
FILELIST = verilog.f
OBJDIR = obj_dir
PASS_MSG = Simulation completed successfully

SIM = $(OBJDIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) rtl/operandDefs.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: sim/operandFetchTb.sv
/* Testbench for the operand-fetch front. Sends random legal and illegal instructions,
   answers writebacks from shadow register files and checks every issued slot. */
`timescale 1ns/100ps
`include "operandDefs.svh"

module operandFetchTb;

    localparam int NumInsns = 600;
    localparam int MaxCycles = 20000;   // roughly 33 cycles per instruction with stalls.
    localparam operandPkg::RegClass CNone = operandPkg::ClassNone;
    localparam operandPkg::RegClass CInt = operandPkg::ClassInt;
    localparam operandPkg::RegClass CFp = operandPkg::ClassFp;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic insnValid = 1'b0;
    logic [31:0] insn = '0;
    logic [`XLEN-1:0] pc = '0;
    logic insnReady;
    logic intWbValid = 1'b0;
    operandPkg::RegAddr intWbAddr = '0;
    operandPkg::IntWord intWbData = '0;
    logic fpWbValid = 1'b0;
    operandPkg::RegAddr fpWbAddr = '0;
    operandPkg::FpWord fpWbData = '0;
    logic execStall = 1'b0;
    logic flushReq = 1'b0;
    logic rrValid;
    logic [`XLEN-1:0] rrPc;
    logic [31:0] rrInsn;
    operandPkg::RegAddr rrRd;
    operandPkg::RegClass rrRdClass;
    operandPkg::TrapCause rrTrapCause;
    operandPkg::IntWord rrIntValue1, rrIntValue2;
    operandPkg::FpWord rrFpValue1, rrFpValue2, rrFpValue3;

    logic [31:0] lfsr = 32'h4e49f758;
    operandPkg::IntWord shadowInt [`NUM_REGS];
    operandPkg::FpWord shadowFp [`NUM_REGS];
    logic [`NUM_REGS-1:0] pendInt, pendFp;        // destinations issued and not yet written back.
    logic [31:0] expPc [$];
    logic [31:0] expInsn [$];
    operandPkg::RegClass wbCls [$];
    operandPkg::RegAddr wbReg [$];
    int wbDue [$];
    logic [6:0] legalOps [16];
    logic [6:0] illegalOps [4];
    logic [4:0] fpFunct [8];
    logic holding, flushNow, stallCheck;
    logic [331:0] stallSnap;
    int errors = 0;
    int checks = 0;
    int cycle = 0;
    int sent = 0;

    operandFetchTop dut_i (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (cycle >= MaxCycles) begin
            $display("Timeout after %0d cycles, %0d instructions sent.", cycle, sent);
            $display("Simulation failed");
            $finish;
        end
    end

    // Galois LFSR that steps once per bit handed out.
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA3000000) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic check(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("ERROR %0t: %s", $time, msg);
        end
    endtask

    // ---------------------------------------------------------------------
    // Reference decode. Bit 8 flags an illegal opcode, then src1..src3 and rd.
    // ---------------------------------------------------------------------
    function automatic logic [8:0] expectedClasses(input logic [31:0] w);
        logic [7:0] cls;
        logic illegal;
        logic twoSrc;
        logic toInt;
        cls = '0;
        illegal = 1'b0;
        twoSrc = w[31:27] <= 5'b00101 || w[31:27] == 5'b10100;   // ops that read rs2.
        toInt = w[31:27] == 5'b10100 || w[31:27] == 5'b11000 || w[31:27] == 5'b11100;
        case (w[6:0])
            7'b0110011: cls = {CInt, CInt, CNone, CInt};
            7'b0010011, 7'b0000011, 7'b1100111: cls = {CInt, CNone, CNone, CInt};
            7'b0100011, 7'b1100011: cls = {CInt, CInt, CNone, CNone};
            7'b1101111, 7'b0110111, 7'b0010111: cls = {CNone, CNone, CNone, CInt};
            7'b0000111: cls = {CInt, CNone, CNone, CFp};        // fld reads an integer base.
            7'b0100111: cls = {CInt, CFp, CNone, CNone};
            7'b1010011: cls = {CFp, twoSrc ? CFp : CNone, CNone, toInt ? CInt : CFp};
            7'b1000011, 7'b1000111, 7'b1001011, 7'b1001111: cls = {CFp, CFp, CFp, CFp};
            default: illegal = 1'b1;
        endcase
        if (cls[1:0] == CInt && w[11:7] == 5'd0) begin
            cls[1:0] = CNone;
        end
        return {illegal, cls};
    endfunction

    function automatic logic isPending(input operandPkg::RegAddr r, input logic [1:0] c);
        return (c == CInt && pendInt[r]) || (c == CFp && pendFp[r]);
    endfunction

    function automatic logic [331:0] rrSnapshot();
        return {rrValid, rrPc, rrInsn, rrRd, rrRdClass, rrTrapCause, rrIntValue1,
                rrIntValue2, rrFpValue1, rrFpValue2, rrFpValue3};
    endfunction

    function automatic logic [31:0] makeInsn();
        logic [31:0] w;
        w = randBits(32);
        if (randBits(3) == 0) begin
            w[6:0] = illegalOps[2'(randBits(2))];
        end
        else begin
            w[6:0] = legalOps[4'(randBits(4))];
        end
        if (w[6:0] == 7'b1010011) begin
            w[31:27] = fpFunct[3'(randBits(3))];
        end
        return w;
    endfunction

    // ---------------------------------------------------------------------
    // Writeback responder.
    // ---------------------------------------------------------------------
    task automatic driveWritebacks();
        int ii;
        int fi;
        ii = -1;
        fi = -1;
        for (int k = 0; k < wbCls.size(); k++) begin
            if (wbDue[k] <= cycle && wbCls[k] == CInt && ii < 0) ii = k;
            if (wbDue[k] <= cycle && wbCls[k] == CFp && fi < 0) fi = k;
        end
        intWbValid = ii >= 0;
        fpWbValid = fi >= 0;
        if (intWbValid) begin
            intWbAddr = wbReg[ii];
            intWbData = randBits(32);
            shadowInt[intWbAddr] = intWbData;
            pendInt[intWbAddr] = 1'b0;
        end
        if (fpWbValid) begin
            fpWbAddr = wbReg[fi];
            fpWbData = {randBits(32), randBits(32)};
            shadowFp[fpWbAddr] = fpWbData;
            pendFp[fpWbAddr] = 1'b0;
        end
        // one writeback frees the register, so later writes to it are answered too.
        for (int k = wbCls.size() - 1; k >= 0; k--) begin
            if ((intWbValid && wbCls[k] == CInt && wbReg[k] == intWbAddr) ||
                (fpWbValid && wbCls[k] == CFp && wbReg[k] == fpWbAddr)) begin
                wbCls.delete(k);
                wbReg.delete(k);
                wbDue.delete(k);
            end
        end
    endtask

    task automatic checkIssue();
        logic [31:0] ei;
        logic [8:0] cls;
        operandPkg::RegAddr r1, r2, r3, rd;
        check(expPc.size() > 0, "an instruction issued that was never expected");
        if (expPc.size() > 0) begin
            ei = expInsn.pop_front();
            check(rrPc == expPc[0], $sformatf("pc %h issued, expected %h", rrPc, expPc[0]));
            void'(expPc.pop_front());
            cls = expectedClasses(ei);
            r1 = ei[19:15];
            r2 = ei[24:20];
            r3 = ei[31:27];
            rd = ei[11:7];
            check(rrInsn == ei && rrRd == rd, $sformatf("insn %h issued as %h", ei, rrInsn));
            check(rrTrapCause == (cls[8] ? operandPkg::TrapIllegalInsn : operandPkg::TrapNone),
                  $sformatf("trap cause %0d for insn %h", rrTrapCause, ei));
            check(rrRdClass == cls[1:0], $sformatf("rd class %0d for insn %h", rrRdClass, ei));
            check(!isPending(r1, cls[7:6]) && !isPending(r2, cls[5:4]) &&
                  !isPending(r3, cls[3:2]), $sformatf("insn %h issued with a pending source", ei));
            check(rrIntValue1 == (cls[7:6] == CInt ? shadowInt[r1] : '0), "int operand 1 wrong");
            check(rrIntValue2 == (cls[5:4] == CInt ? shadowInt[r2] : '0), "int operand 2 wrong");
            check(rrFpValue1 == (cls[7:6] == CFp ? shadowFp[r1] : '0), "fp operand 1 wrong");
            check(rrFpValue2 == (cls[5:4] == CFp ? shadowFp[r2] : '0), "fp operand 2 wrong");
            check(rrFpValue3 == (cls[3:2] == CFp ? shadowFp[r3] : '0), "fp operand 3 wrong");
            if (cls[1:0] == CInt) pendInt[rd] = 1'b1;
            if (cls[1:0] == CFp) pendFp[rd] = 1'b1;
            if (cls[1:0] != CNone) begin
                wbCls.push_back(operandPkg::RegClass'(cls[1:0]));
                wbReg.push_back(rd);
                wbDue.push_back(cycle + 1 + int'(randBits(3)));
            end
        end
    endtask

    // inputs change on the falling edge and outcomes are predicted for the next rising one.
    task automatic stepCycle();
        @(negedge clk);
        cycle++;
        if (stallCheck) check(rrSnapshot() == stallSnap, "rr outputs moved under execStall");
        driveWritebacks();
        flushNow = flushReq;
        execStall = randBits(5) < 6;
        flushReq = sent < NumInsns && randBits(7) == 0;
        if (!holding) begin
            insnValid = sent < NumInsns && randBits(2) != 0;
            if (insnValid) begin
                insn = makeInsn();
                pc = pc + 4;
            end
        end
        #1;
        if (rrValid && !execStall) checkIssue();
        if (flushNow) begin
            expPc.delete();                                     // everything still in flight dies.
            expInsn.delete();
        end
        else if (insnValid && insnReady) begin
            expPc.push_back(pc);
            expInsn.push_back(insn);
        end
        if (insnValid && insnReady) sent++;
        holding = insnValid && !insnReady;
        stallCheck = execStall && !flushNow;
        stallSnap = rrSnapshot();
    endtask

    initial begin
        legalOps = '{7'h33, 7'h13, 7'h03, 7'h23, 7'h63, 7'h6f, 7'h67, 7'h37,
                     7'h17, 7'h07, 7'h27, 7'h53, 7'h43, 7'h47, 7'h4b, 7'h4f};
        illegalOps = '{7'h0b, 7'h2b, 7'h7f, 7'h00};
        fpFunct = '{5'b00000, 5'b00001, 5'b10100, 5'b11000, 5'b11100, 5'b00000,
                    5'b00011, 5'b10100};
        for (int i = 0; i < `NUM_REGS; i++) begin
            shadowInt[i] = '0;
            shadowFp[i] = '0;
        end
        pendInt = '0;
        pendFp = '0;
        holding = 1'b0;
        flushNow = 1'b0;
        stallCheck = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check(!rrValid && !dut_i.decValid && insnReady, "pipeline not idle after reset");
        while (!(sent >= NumInsns && expPc.size() == 0 && wbCls.size() == 0)) begin
            stepCycle();
        end
        $display("Checks: %0d, errors: %0d, instructions sent: %0d, cycles: %0d",
                 checks, errors, sent, cycle);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: rtl/operandFetchTop.sv
/* Operand-fetch front of the RV32 core. Connects the decoder, the controller,
   both register files and the register-read stage. */
`timescale 1ns/100ps
`include "operandDefs.svh"

module operandFetchTop (
    input  logic clk,
    input  logic rst,
    input  logic insnValid,
    input  logic [31:0] insn,
    input  logic [`XLEN-1:0] pc,
    output logic insnReady,
    input  logic intWbValid,
    input  operandPkg::RegAddr intWbAddr,
    input  operandPkg::IntWord intWbData,
    input  logic fpWbValid,
    input  operandPkg::RegAddr fpWbAddr,
    input  operandPkg::FpWord fpWbData,
    input  logic execStall,
    input  logic flushReq,
    output logic rrValid,
    output logic [`XLEN-1:0] rrPc,
    output logic [31:0] rrInsn,
    output operandPkg::RegAddr rrRd,
    output operandPkg::RegClass rrRdClass,
    output operandPkg::TrapCause rrTrapCause,
    output operandPkg::IntWord rrIntValue1,
    output operandPkg::IntWord rrIntValue2,
    output operandPkg::FpWord rrFpValue1,
    output operandPkg::FpWord rrFpValue2,
    output operandPkg::FpWord rrFpValue3
);

    logic decValid, decStall, rrStall, rrBubble, flush;
    logic [`XLEN-1:0] decPc;
    logic [31:0] decInsn;
    operandPkg::RegAddr decRs1, decRs2, decRs3, decRd;
    operandPkg::RegClass src1Class, src2Class, src3Class, rdClass;
    operandPkg::TrapCause decTrapCause;
    operandPkg::RegAddr intReadAddr [2];
    operandPkg::RegAddr fpReadAddr [3];
    operandPkg::IntWord intReadValue [2];
    operandPkg::FpWord fpReadValue [3];

    assign insnReady = !decStall;

    insnDecoder decoder_i (
        .clk, .rst, .insnValid, .insn, .pc, .stall(decStall), .flush,
        .decValid, .decPc, .decInsn, .decRs1, .decRs2, .decRs3, .decRd,
        .src1Class, .src2Class, .src3Class, .rdClass, .decTrapCause
    );

    pipelineCtrl ctrl_i (
        .clk, .rst, .flushReq, .execStall,
        .decValid, .decRs1, .decRs2, .decRs3, .src1Class, .src2Class, .src3Class,
        .rrValid, .rrRd, .rrRdClass,
        .intWbValid, .intWbAddr, .fpWbValid, .fpWbAddr,
        .decStall, .rrStall, .rrBubble, .flush
    );

    regFile #(.WordType(operandPkg::IntWord), .NumReadPorts(2), .HasZeroReg(1'b1)) intRegs (
        .clk, .rst, .readAddr(intReadAddr), .readValue(intReadValue),
        .writeEnable(intWbValid), .writeAddr(intWbAddr), .writeData(intWbData)
    );

    regFile #(.WordType(operandPkg::FpWord), .NumReadPorts(3), .HasZeroReg(1'b0)) fpRegs (
        .clk, .rst, .readAddr(fpReadAddr), .readValue(fpReadValue),
        .writeEnable(fpWbValid), .writeAddr(fpWbAddr), .writeData(fpWbData)
    );

    regReadStage regRead_i (
        .clk, .rst,
        .decValid, .decPc, .decInsn, .decRs1, .decRs2, .decRs3, .decRd,
        .src1Class, .src2Class, .src3Class, .rdClass, .decTrapCause,
        .stall(rrStall), .bubble(rrBubble), .flush,
        .intReadAddr, .fpReadAddr, .intReadValue, .fpReadValue,
        .rrValid, .rrPc, .rrInsn, .rrRd, .rrRdClass, .rrTrapCause,
        .rrIntValue1, .rrIntValue2, .rrFpValue1, .rrFpValue2, .rrFpValue3
    );

endmodule

// File: rtl/pipelineCtrl.sv
/* Pipeline controller. Tracks registers with writes outstanding and drives the
   stall, bubble and flush controls of the decode and register-read stages. */
`timescale 1ns/100ps
`include "operandDefs.svh"

module pipelineCtrl (
    input  logic clk,
    input  logic rst,
    input  logic flushReq,
    input  logic execStall,
    input  logic decValid,
    input  operandPkg::RegAddr decRs1,
    input  operandPkg::RegAddr decRs2,
    input  operandPkg::RegAddr decRs3,
    input  operandPkg::RegClass src1Class,
    input  operandPkg::RegClass src2Class,
    input  operandPkg::RegClass src3Class,
    input  logic rrValid,
    input  operandPkg::RegAddr rrRd,
    input  operandPkg::RegClass rrRdClass,
    input  logic intWbValid,
    input  operandPkg::RegAddr intWbAddr,
    input  logic fpWbValid,
    input  operandPkg::RegAddr fpWbAddr,
    output logic decStall,
    output logic rrStall,
    output logic rrBubble,
    output logic flush
);

    logic [`NUM_REGS-1:0] intBusy;
    logic [`NUM_REGS-1:0] fpBusy;
    logic rrLeaving;
    logic hazard;

    // a source waits if its register is busy, unless the writeback lands now,
    // or if the instruction in register read is about to write it.
    function automatic logic srcHazard(input operandPkg::RegAddr addr,
                                       input operandPkg::RegClass cls);
        logic busy;
        logic inFlight;
        busy = 1'b0;
        if (cls == operandPkg::ClassInt) begin
            busy = intBusy[addr] && !(intWbValid && intWbAddr == addr);
        end
        else if (cls == operandPkg::ClassFp) begin
            busy = fpBusy[addr] && !(fpWbValid && fpWbAddr == addr);
        end
        inFlight = rrValid && !flush && cls != operandPkg::ClassNone &&
                   rrRdClass == cls && rrRd == addr;
        return busy || inFlight;
    endfunction

    assign rrLeaving = rrValid && !execStall;

    always_comb begin
        hazard = decValid && (srcHazard(decRs1, src1Class) ||
                              srcHazard(decRs2, src2Class) ||
                              srcHazard(decRs3, src3Class));
        rrStall = execStall;
        decStall = execStall || hazard;
        rrBubble = hazard && !execStall;
    end

    // ---------------------------------------------------------------------
    // Scoreboard. A new outstanding write wins over a writeback to the same register.
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            intBusy <= '0;
            fpBusy <= '0;
            flush <= 1'b0;
        end
        else begin
            flush <= flushReq;
            if (intWbValid) intBusy[intWbAddr] <= 1'b0;
            if (fpWbValid) fpBusy[fpWbAddr] <= 1'b0;
            if (rrLeaving && rrRdClass == operandPkg::ClassInt && rrRd != '0) begin
                intBusy[rrRd] <= 1'b1;
            end
            if (rrLeaving && rrRdClass == operandPkg::ClassFp) begin
                fpBusy[rrRd] <= 1'b1;
            end
        end
    end

    intWbToBusy: assert property (@(posedge clk) disable iff (rst)
        intWbValid |-> intBusy[intWbAddr]);
    fpWbToBusy: assert property (@(posedge clk) disable iff (rst)
        fpWbValid |-> fpBusy[fpWbAddr]);
    noBubbleOnStall: assert property (@(posedge clk) disable iff (rst)
        !(rrBubble && rrStall));

endmodule

// File: rtl/regReadStage.sv
/* Register-read stage. Addresses both register files from the decode outputs
   and registers the operands for execute, with stall, bubble and flush. */
`timescale 1ns/100ps
`include "operandDefs.svh"

module regReadStage (
    input  logic clk,
    input  logic rst,
    input  logic decValid,
    input  logic [`XLEN-1:0] decPc,
    input  logic [31:0] decInsn,
    input  operandPkg::RegAddr decRs1,
    input  operandPkg::RegAddr decRs2,
    input  operandPkg::RegAddr decRs3,
    input  operandPkg::RegAddr decRd,
    input  operandPkg::RegClass src1Class,
    input  operandPkg::RegClass src2Class,
    input  operandPkg::RegClass src3Class,
    input  operandPkg::RegClass rdClass,
    input  operandPkg::TrapCause decTrapCause,
    input  logic stall,
    input  logic bubble,
    input  logic flush,
    output operandPkg::RegAddr intReadAddr [2],
    output operandPkg::RegAddr fpReadAddr [3],
    input  operandPkg::IntWord intReadValue [2],
    input  operandPkg::FpWord fpReadValue [3],
    output logic rrValid,
    output logic [`XLEN-1:0] rrPc,
    output logic [31:0] rrInsn,
    output operandPkg::RegAddr rrRd,
    output operandPkg::RegClass rrRdClass,
    output operandPkg::TrapCause rrTrapCause,
    output operandPkg::IntWord rrIntValue1,
    output operandPkg::IntWord rrIntValue2,
    output operandPkg::FpWord rrFpValue1,
    output operandPkg::FpWord rrFpValue2,
    output operandPkg::FpWord rrFpValue3
);

    always_comb begin
        intReadAddr[0] = decRs1;
        intReadAddr[1] = decRs2;
        fpReadAddr[0] = decRs1;
        fpReadAddr[1] = decRs2;
        fpReadAddr[2] = decRs3;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rrValid <= 1'b0;
            rrPc <= '0;
            rrInsn <= '0;
            rrRd <= '0;
            rrRdClass <= operandPkg::ClassNone;
            rrTrapCause <= operandPkg::TrapNone;
            rrIntValue1 <= '0;
            rrIntValue2 <= '0;
            rrFpValue1 <= '0;
            rrFpValue2 <= '0;
            rrFpValue3 <= '0;
        end
        else if (stall) begin
            rrValid <= rrValid;                                  // execute is not taking it.
        end
        else if (bubble) begin
            rrValid <= 1'b0;                                     // decode waits on a hazard.
        end
        else begin
            rrValid <= decValid;
            rrPc <= decPc;
            rrInsn <= decInsn;
            rrRd <= decRd;
            rrRdClass <= rdClass;
            rrTrapCause <= decTrapCause;
            // an operand slot the instruction does not read from that file is zero.
            rrIntValue1 <= (src1Class == operandPkg::ClassInt) ? intReadValue[0] : '0;
            rrIntValue2 <= (src2Class == operandPkg::ClassInt) ? intReadValue[1] : '0;
            rrFpValue1 <= (src1Class == operandPkg::ClassFp) ? fpReadValue[0] : '0;
            rrFpValue2 <= (src2Class == operandPkg::ClassFp) ? fpReadValue[1] : '0;
            rrFpValue3 <= (src3Class == operandPkg::ClassFp) ? fpReadValue[2] : '0;
        end
    end

endmodule

// File: rtl/insnDecoder.sv
/* Decode stage. Registers an accepted instruction and extracts its register
   specifiers, the register class of every operand and the illegal-opcode trap. */
`timescale 1ns/100ps
`include "operandDefs.svh"

module insnDecoder (
    input  logic clk,
    input  logic rst,
    input  logic insnValid,
    input  logic [31:0] insn,
    input  logic [`XLEN-1:0] pc,
    input  logic stall,
    input  logic flush,
    output logic decValid,
    output logic [`XLEN-1:0] decPc,
    output logic [31:0] decInsn,
    output operandPkg::RegAddr decRs1,
    output operandPkg::RegAddr decRs2,
    output operandPkg::RegAddr decRs3,
    output operandPkg::RegAddr decRd,
    output operandPkg::RegClass src1Class,
    output operandPkg::RegClass src2Class,
    output operandPkg::RegClass src3Class,
    output operandPkg::RegClass rdClass,
    output operandPkg::TrapCause decTrapCause
);

    // ---------------------------------------------------------------------
    // RV32 major opcodes.
    // ---------------------------------------------------------------------
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpLoadFp = 7'b0000111;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpAuipc  = 7'b0010111;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpStoreFp = 7'b0100111;
    localparam logic [6:0] OpReg    = 7'b0110011;
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpMadd   = 7'b1000011;
    localparam logic [6:0] OpMsub   = 7'b1000111;
    localparam logic [6:0] OpNmsub  = 7'b1001011;
    localparam logic [6:0] OpNmadd  = 7'b1001111;
    localparam logic [6:0] OpFp     = 7'b1010011;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJalr   = 7'b1100111;
    localparam logic [6:0] OpJal    = 7'b1101111;

    logic [6:0] opcode;
    logic [4:0] funct5;
    operandPkg::RegClass cls1, cls2, cls3, clsRd;
    operandPkg::TrapCause cause;

    assign opcode = insn[6:0];
    assign funct5 = insn[31:27];

    always_comb begin
        cls1 = operandPkg::ClassNone;
        cls2 = operandPkg::ClassNone;
        cls3 = operandPkg::ClassNone;
        clsRd = operandPkg::ClassNone;
        cause = operandPkg::TrapNone;
        case (opcode)
            OpReg, OpStore, OpBranch: begin
                cls1 = operandPkg::ClassInt;
                cls2 = operandPkg::ClassInt;
                clsRd = (opcode == OpReg) ? operandPkg::ClassInt : operandPkg::ClassNone;
            end
            OpImm, OpLoad, OpJalr: begin
                cls1 = operandPkg::ClassInt;
                clsRd = operandPkg::ClassInt;
            end
            OpJal, OpLui, OpAuipc: clsRd = operandPkg::ClassInt;
            OpLoadFp, OpStoreFp: begin
                cls1 = operandPkg::ClassInt;                     // integer base address.
                cls2 = (opcode == OpStoreFp) ? operandPkg::ClassFp : operandPkg::ClassNone;
                clsRd = (opcode == OpLoadFp) ? operandPkg::ClassFp : operandPkg::ClassNone;
            end
            OpFp: begin
                // fcvt.d.w and fmv.d.x take an integer source.
                cls1 = (funct5 == 5'b11010 || funct5 == 5'b11110) ?
                       operandPkg::ClassInt : operandPkg::ClassFp;
                // only the two-operand arithmetic ops and the compares read rs2.
                cls2 = (funct5[4:3] == 2'b00 || funct5 == 5'b10100) ?
                       operandPkg::ClassFp : operandPkg::ClassNone;
                // fcmp, fcvt to int and fmv.x/fclass write the integer file.
                clsRd = (funct5 == 5'b10100 || funct5 == 5'b11000 || funct5 == 5'b11100) ?
                        operandPkg::ClassInt : operandPkg::ClassFp;
            end
            OpMadd, OpMsub, OpNmsub, OpNmadd: begin
                cls1 = operandPkg::ClassFp;
                cls2 = operandPkg::ClassFp;
                cls3 = operandPkg::ClassFp;
                clsRd = operandPkg::ClassFp;
            end
            default: cause = operandPkg::TrapIllegalInsn;
        endcase
        if (clsRd == operandPkg::ClassInt && insn[11:7] == '0) begin
            clsRd = operandPkg::ClassNone;                       // writes to x0 are dropped.
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            decValid <= 1'b0;
            decTrapCause <= operandPkg::TrapNone;
        end
        else if (!stall) begin
            decValid <= insnValid;
            decPc <= pc;
            decInsn <= insn;
            decRs1 <= insn[19:15];
            decRs2 <= insn[24:20];
            decRs3 <= insn[31:27];
            decRd <= insn[11:7];
            src1Class <= cls1;
            src2Class <= cls2;
            src3Class <= cls3;
            rdClass <= clsRd;
            decTrapCause <= insnValid ? cause : operandPkg::TrapNone;
        end
    end

    trapOnlyWhenValid: assert property (@(posedge clk) disable iff (rst)
        decTrapCause != operandPkg::TrapNone |-> decValid);

endmodule

// File: rtl/regFile.sv
/* Register file with a configurable word type and read-port count.
   Serves both the integer file (x0 hardwired) and the floating-point file. */
`timescale 1ns/100ps
`include "operandDefs.svh"

module regFile #(
    parameter type WordType = operandPkg::IntWord,
    parameter int NumReadPorts = 2,
    parameter bit HasZeroReg = 1'b1
) (
    input  logic clk,
    input  logic rst,
    input  operandPkg::RegAddr readAddr [NumReadPorts],
    output WordType readValue [NumReadPorts],
    input  logic writeEnable,
    input  operandPkg::RegAddr writeAddr,
    input  WordType writeData
);

    WordType regs [`NUM_REGS];
    logic writeAllowed;

    // writes to a hardwired zero register are dropped here.
    assign writeAllowed = writeEnable && !(HasZeroReg && writeAddr == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end
        else if (writeAllowed) begin
            regs[writeAddr] <= writeData;
        end
    end

    // a reader of the register being written sees the new value.
    always_comb begin
        for (int p = 0; p < NumReadPorts; p++) begin
            if (HasZeroReg && readAddr[p] == '0) begin
                readValue[p] = '0;
            end
            else if (writeAllowed && writeAddr == readAddr[p]) begin
                readValue[p] = writeData;
            end
            else begin
                readValue[p] = regs[readAddr[p]];
            end
        end
    end

    // register 0 keeps its reset value across any write aimed at it.
    zeroRegKept: assert property (@(posedge clk) disable iff (rst)
        HasZeroReg && writeEnable && writeAddr == '0 |=> regs[0] == '0);

endmodule

// File: rtl/operandPkg.sv
/* Types shared by the decode, register-read and control blocks of the operand-fetch front.
   Referenced as operandPkg::name, never imported. */
`include "operandDefs.svh"

package operandPkg;

    // register specifier as it appears in the instruction word.
    typedef logic [`REG_ADDR_W-1:0] RegAddr;

    // register file words.
    typedef logic [`XLEN-1:0] IntWord;
    typedef logic [`FLEN-1:0] FpWord;

    // which file an operand or a destination lives in.
    typedef enum logic [1:0] {
        ClassNone = 2'd0,
        ClassInt  = 2'd1,
        ClassFp   = 2'd2
    } RegClass;

    // trap codes follow the privileged-spec mcause numbering.
    typedef enum logic [3:0] {
        TrapNone        = 4'd0,
        TrapIllegalInsn = 4'd2
    } TrapCause;

endpackage

// File: rtl/operandDefs.svh
/* Width and size macros shared by the operand-fetch RTL and its testbench.
   Include this file wherever one of the macros is needed. */
`ifndef OPERAND_DEFS_SVH
`define OPERAND_DEFS_SVH

// ---------------------------------------------------------------------
// Datapath widths.
// ---------------------------------------------------------------------
`define XLEN 32        // integer register and pc width.
`define FLEN 64        // double-precision floating-point register width.

// ---------------------------------------------------------------------
// Register files.
// ---------------------------------------------------------------------
`define REG_ADDR_W 5   // bits in a register specifier.
`define NUM_REGS 32    // registers in each file.

`endif
